//--- isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] imm_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	localparam int NUM_REGS = 32;

	// Low bit of each instruction field; the width comes from the field's type.
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_LSB    = 0;

	// ==================================================
	// Opcodes.
	// ==================================================
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_SLTIU = 6'b001011;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_LUI   = 6'b001111;

	// Function codes, valid only with OP_RTYPE.
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

	// ALU operations. The encoding is internal to the pipeline and
	// does not appear in any instruction field.
	typedef enum logic [2:0] {
		ALU_AND  = 3'b000,
		ALU_OR   = 3'b001,
		ALU_ADD  = 3'b010,
		ALU_SUB  = 3'b110,
		ALU_SLT  = 3'b111,
		ALU_SLTU = 3'b101
	} alu_op_t;

	// Shift applied to the immediate by lui.
	localparam int SHIFT_LUI = 16;

	// Clock edges from the issue edge until the result shows at the
	// writeback port. One edge for the decode-to-execute register and one for
	// the execute-to-writeback register.
	localparam int PIPE_LATENCY = 2;

endpackage

//--- stage_if.sv
// Decoded instruction and its operands, from decode into execute.
interface ex_bus_if;
	import isa_pkg::*;
	import pipe_pkg::*;

	logic      regwrite;
	reg_addr_t writereg;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t     rd1;
	word_t     rd2;
	word_t     imm;      // Already extended to a full word.
	logic      alusrc;   // High selects imm for operand b.
	logic      shiftl16;
	alu_op_t   alu_op;

	modport producer (
		output regwrite, writereg, rs, rt, rd1, rd2, imm, alusrc, shiftl16, alu_op
	);

	modport consumer (
		input regwrite, writereg, rs, rt, rd1, rd2, imm, alusrc, shiftl16, alu_op
	);

endinterface

// Writeback register contents. They feed the register file write port,
// the read bypass, the forwarding path and the top-level outputs.
interface wb_bus_if;
	import isa_pkg::*;

	logic      regwrite;
	reg_addr_t writereg;
	word_t     result;

	modport producer (
		output regwrite, writereg, result
	);

	modport writer_port (
		input regwrite, writereg, result
	);

endinterface

//--- reg_file.sv
module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  isa_pkg::reg_addr_t ra1,
	input  isa_pkg::reg_addr_t ra2,
	output isa_pkg::word_t    rd1,
	output isa_pkg::word_t    rd2,
	wb_bus_if.writer_port     wb
);
	import isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regwrite) begin
			regs[wb.writereg] <= wb.result;
		end
	end

	// A read of the register being written this cycle sees the new value.
	// The writeback bus never carries a write to register 0.
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wb.regwrite && wb.writereg == addr) begin
			value = wb.result;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rd1 = read_port(ra1);
		rd2 = read_port(ra2);
	end

endmodule

//--- alu.sv
module alu (
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	input  pipe_pkg::alu_op_t op,
	output isa_pkg::word_t   result
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic  negate;
	word_t b_in;
	word_t sum;
	logic  carry;
	logic  overflow;
	logic  lt_signed;
	logic  lt_unsigned;

	// Subtract and both compares work on a - b.
	assign negate = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
	assign b_in   = negate ? ~b : b;

	assign {carry, sum} = {1'b0, a} + {1'b0, b_in} + {{$bits(word_t){1'b0}}, negate};

	// Overflow when both addends share a sign that the sum does not.
	assign overflow    = (a[$bits(word_t)-1] == b_in[$bits(word_t)-1]) &&
	                     (sum[$bits(word_t)-1] != a[$bits(word_t)-1]);
	assign lt_signed   = sum[$bits(word_t)-1] ^ overflow;
	assign lt_unsigned = ~carry; // No carry out means a borrow.

	always_comb begin
		case (op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_ADD:  result = sum;
			ALU_SUB:  result = sum;
			ALU_SLT:  result = word_t'(lt_signed);
			ALU_SLTU: result = word_t'(lt_unsigned);
			default:  result = '0;
		endcase
	end

endmodule

//--- decode_stage.sv
module decode_stage (
	input  logic          clk,
	input  logic          reset,
	input  logic          instr_valid,
	input  isa_pkg::instr_t instr,
	ex_bus_if.producer    ex,
	wb_bus_if.writer_port wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic      issue_valid;
	instr_t    issue_instr;
	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs, rt, rd;
	imm_t      imm_field;
	logic      supported;
	logic      sign_ext;
	logic      alusrc;
	logic      shiftl16;
	alu_op_t   alu_op;
	reg_addr_t src_a;
	reg_addr_t dest;
	word_t     imm_ext;
	word_t     rd1, rd2;

	// ==================================================
	// Issue register.
	// ==================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issue_valid <= 1'b0;
			issue_instr <= '0;
		end else begin
			issue_valid <= instr_valid;
			issue_instr <= instr;
		end
	end

	assign opcode    = issue_instr[OPCODE_LSB +: $bits(opcode_t)];
	assign funct     = issue_instr[FUNCT_LSB +: $bits(funct_t)];
	assign rs        = issue_instr[RS_LSB +: $bits(reg_addr_t)];
	assign rt        = issue_instr[RT_LSB +: $bits(reg_addr_t)];
	assign rd        = issue_instr[RD_LSB +: $bits(reg_addr_t)];
	assign imm_field = issue_instr[IMM_LSB +: $bits(imm_t)];

	// ==================================================
	// Decoder.
	// ==================================================
	always_comb begin
		supported = 1'b1;
		alu_op    = ALU_ADD;
		alusrc    = 1'b1;
		shiftl16  = 1'b0;
		sign_ext  = 1'b1;
		src_a     = rs;
		dest      = rt;
		case (opcode)
			OP_RTYPE: begin
				alusrc = 1'b0;
				dest   = rd;
				case (funct)
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					default: supported = 1'b0;
				endcase
			end
			OP_ADDI:  alu_op = ALU_ADD;
			OP_SLTI:  alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU; // Sign-extended, then compared unsigned.
			OP_ANDI: begin
				alu_op   = ALU_AND;
				sign_ext = 1'b0;
			end
			OP_ORI: begin
				alu_op   = ALU_OR;
				sign_ext = 1'b0;
			end
			OP_LUI: begin
				// Computed as r0 | (imm << 16).
				alu_op   = ALU_OR;
				sign_ext = 1'b0;
				shiftl16 = 1'b1;
				src_a    = '0;
			end
			default: supported = 1'b0;
		endcase
	end

	assign imm_ext = sign_ext ? word_t'(signed'(imm_field)) : word_t'(imm_field);

	reg_file u_reg_file (
		.clk   (clk),
		.reset (reset),
		.ra1   (src_a),
		.ra2   (rt),
		.rd1   (rd1),
		.rd2   (rd2),
		.wb    (wb)
	);

	// ==================================================
	// Decode-to-execute register.
	// ==================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex.regwrite <= 1'b0;
			ex.writereg <= '0;
			ex.rs       <= '0;
			ex.rt       <= '0;
			ex.rd1      <= '0;
			ex.rd2      <= '0;
			ex.imm      <= '0;
			ex.alusrc   <= 1'b0;
			ex.shiftl16 <= 1'b0;
			ex.alu_op   <= ALU_AND;
		end else begin
			ex.regwrite <= issue_valid && supported && (dest != '0); // Bubbles never write.
			ex.writereg <= dest;
			ex.rs       <= src_a;
			ex.rt       <= rt;
			ex.rd1      <= rd1;
			ex.rd2      <= rd2;
			ex.imm      <= imm_ext;
			ex.alusrc   <= alusrc;
			ex.shiftl16 <= shiftl16;
			ex.alu_op   <= alu_op;
		end
	end

endmodule

//--- execute_stage.sv
module execute_stage (
	input logic        clk,
	input logic        reset,
	ex_bus_if.consumer ex,
	wb_bus_if.producer wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic  fwd_rs;
	logic  fwd_rt;
	word_t src_a;
	word_t src_rt;
	word_t imm_val;
	word_t src_b;
	word_t alu_result;

	// ==================================================
	// Forwarding from the writeback register.
	// ==================================================
	// A writeback to r0 never has regwrite set, so no zero check is needed.
	assign fwd_rs = wb.regwrite && (wb.writereg == ex.rs);
	assign fwd_rt = wb.regwrite && (wb.writereg == ex.rt);

	assign src_a  = fwd_rs ? wb.result : ex.rd1;
	assign src_rt = fwd_rt ? wb.result : ex.rd2;

	assign imm_val = ex.shiftl16 ? (ex.imm << SHIFT_LUI) : ex.imm;
	assign src_b   = ex.alusrc ? imm_val : src_rt;

	alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (ex.alu_op),
		.result (alu_result)
	);

	// Execute-to-writeback register.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb.regwrite <= 1'b0;
			wb.writereg <= '0;
			wb.result   <= '0;
		end else begin
			wb.regwrite <= ex.regwrite;
			wb.writereg <= ex.writereg;
			wb.result   <= alu_result;
		end
	end

endmodule

//--- mips_int_pipe.sv
module mips_int_pipe (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  isa_pkg::instr_t    instr,
	output logic               wb_valid,
	output isa_pkg::reg_addr_t wb_reg,
	output isa_pkg::word_t     wb_data
);

	ex_bus_if ex_bus ();
	wb_bus_if wb_bus ();

	decode_stage u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ex          (ex_bus.producer),
		.wb          (wb_bus.writer_port)
	);

	execute_stage u_execute (
		.clk   (clk),
		.reset (reset),
		.ex    (ex_bus.consumer),
		.wb    (wb_bus.producer)
	);

	// The writeback register is visible for exactly one cycle per instruction.
	assign wb_valid = wb_bus.regwrite;
	assign wb_reg   = wb_bus.writereg;
	assign wb_data  = wb_bus.result;

endmodule

//--- tb_mips_int_pipe.sv
module tb_mips_int_pipe;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLK_PERIOD    = 10;
	localparam int DRAIN         = PIPE_LATENCY + 1;
	localparam int ITYPE_COUNT   = 150;
	localparam int RTYPE_COUNT   = 150;
	localparam int DIST_ITERS    = 40; // Up to seven issue slots each.
	localparam int NOWRITE_ITERS = 40;
	localparam int TOTAL_SLOTS   = 13 + ITYPE_COUNT + RTYPE_COUNT + 7 * DIST_ITERS +
	                               2 * NOWRITE_ITERS + 5 * DRAIN;
	localparam int WATCHDOG_TIME = (TOTAL_SLOTS + 100) * CLK_PERIOD;

	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     data;
	} slot_t;

	logic      clk;
	logic      reset;
	logic      instr_valid;
	instr_t    instr;
	logic      wb_valid;
	reg_addr_t wb_reg;
	word_t     wb_data;

	word_t       model_regs [NUM_REGS];
	slot_t       exp_q [$];   // One entry per issue slot, bubbles included.
	logic [31:0] lfsr_state = 32'd8;
	string       cur_test;
	int          checks, errors, tests_run, test_checks, test_errors;

	mips_int_pipe dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the run did not finish within %0d time units.", WATCHDOG_TIME);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ==================================================
	// Stimulus helpers.
	// ==================================================
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        bit_out;
		value = '0;
		for (int i = 0; i < n; i++) begin
			bit_out    = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (bit_out) lfsr_state = lfsr_state ^ 32'hD000_0001;
			value = {value[30:0], bit_out};
		end
		return value;
	endfunction

	function automatic reg_addr_t rand_reg(input logic nonzero);
		reg_addr_t r;
		do r = reg_addr_t'(rand_bits(3)); while (nonzero && r == '0);
		return r;
	endfunction

	function automatic funct_t rand_funct();
		logic [31:0] sel;
		funct_t      table_fn [6];
		table_fn = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU};
		do sel = rand_bits(3); while (sel > 5);
		return table_fn[sel];
	endfunction

	function automatic instr_t make_r(input funct_t fn, input reg_addr_t rs, rt, rd);
		return {OP_RTYPE, rs, rt, rd, 5'b0, fn};
	endfunction

	function automatic instr_t make_i(input opcode_t op, input reg_addr_t rs, rt, input imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	// Reference model. Instructions retire in program order with no pipeline.
	task automatic model_exec(input instr_t w, output slot_t s);
		reg_addr_t rs, rt, dest;
		imm_t      imm;
		word_t     a, b, sx, zx, res;
		logic      ok;
		rs   = w[25:21];
		rt   = w[20:16];
		imm  = w[15:0];
		a    = model_regs[rs];
		b    = model_regs[rt];
		sx   = {{16{imm[15]}}, imm};
		zx   = {16'h0000, imm};
		ok   = 1'b1;
		dest = rt;
		res  = '0;
		case (opcode_t'(w[31:26]))
			OP_RTYPE: begin
				dest = w[15:11];
				case (funct_t'(w[5:0]))
					FN_ADD:  res = a + b;
					FN_SUB:  res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
					FN_SLTU: res = {31'b0, a < b};
					default: ok = 1'b0;
				endcase
			end
			OP_ADDI:  res = a + sx;
			OP_SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
			OP_SLTIU: res = {31'b0, a < sx}; // Sign-extended immediate, unsigned compare.
			OP_ANDI:  res = a & zx;
			OP_ORI:   res = a | zx;
			OP_LUI:   res = {imm, 16'h0000};
			default:  ok = 1'b0;
		endcase
		s.valid = ok && (dest != '0);
		s.dest  = dest;
		s.data  = res;
		if (s.valid) model_regs[dest] = res;
	endtask

	// ==================================================
	// Compare tasks.
	// ==================================================
	task automatic check_word(input string what, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_reg(input string what, input reg_addr_t expected, input reg_addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s %s: expected r%0d, actual r%0d", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, expected, actual);
		end
	endtask

	// One falling edge. The slot issued PIPE_LATENCY edges ago is due at the outputs now.
	task automatic issue_slot(input logic valid, input instr_t word);
		slot_t due, next;
		@(negedge clk);
		if (exp_q.size() > PIPE_LATENCY) begin
			due = exp_q.pop_front();
			check_bit("wb_valid", due.valid, wb_valid);
			if (due.valid) begin
				check_reg("wb_reg", due.dest, wb_reg);
				check_word("wb_data", due.data, wb_data);
			end
		end else begin
			check_bit("wb_valid", 1'b0, wb_valid);
		end
		instr_valid = valid;
		instr       = word;
		next        = '0;
		if (valid) model_exec(word, next);
		exp_q.push_back(next);
	endtask

	task automatic issue_bubble();
		issue_slot(1'b0, rand_bits(32)); // Garbage on instr must be ignored.
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		repeat (DRAIN) issue_bubble();
		tests_run++;
		$display("%s: %0d checks, %0d errors", cur_test, checks - test_checks,
		         errors - test_errors);
	endtask

	// ==================================================
	// Tests.
	// ==================================================
	task automatic run_tests();
		reg_addr_t   prev, d, e;
		logic [31:0] sel, raw;
		opcode_t     op;
		funct_t      fn;
		opcode_t     iops [6];
		iops = '{OP_ADDI, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_LUI};

		begin_test("reset");
		repeat (2) issue_bubble();
		reset = 1'b0;
		repeat (4) issue_bubble();
		for (int i = 1; i < 8; i++) begin
			issue_slot(1'b1, make_r(FN_ADD, reg_addr_t'(i), reg_addr_t'(i % 7 + 1), reg_addr_t'(i)));
		end
		end_test();

		begin_test("itype");
		for (int n = 0; n < ITYPE_COUNT; n++) begin
			do sel = rand_bits(3); while (sel > 5);
			issue_slot(1'b1, make_i(iops[sel], rand_reg(0), rand_reg(0), imm_t'(rand_bits(16))));
		end
		end_test();

		begin_test("rtype_chain");
		prev = rand_reg(1);
		for (int n = 0; n < RTYPE_COUNT; n++) begin
			d = rand_reg(1);
			if (rand_bits(1)) issue_slot(1'b1, make_r(rand_funct(), prev, rand_reg(0), d));
			else issue_slot(1'b1, make_r(rand_funct(), rand_reg(0), prev, d));
			prev = d;
		end
		end_test();

		begin_test("distance_two");
		for (int n = 0; n < DIST_ITERS; n++) begin
			d = rand_reg(1);
			e = rand_reg(1);
			issue_slot(1'b1, make_r(rand_funct(), rand_reg(0), rand_reg(0), d));
			if (rand_bits(1) || e == d) issue_bubble();
			else issue_slot(1'b1, make_i(OP_ORI, rand_reg(0), e, imm_t'(rand_bits(16))));
			issue_slot(1'b1, make_r(rand_funct(), d, rand_reg(0), e));
			repeat (1 + rand_bits(2) % 3) issue_bubble();
			issue_slot(1'b1, make_r(rand_funct(), rand_reg(0), e, rand_reg(1)));
		end
		end_test();

		begin_test("no_write");
		for (int n = 0; n < NOWRITE_ITERS; n++) begin
			do sel = rand_bits(2); while (sel > 2);
			raw = rand_bits(26);
			if (sel == 0) begin
				issue_slot(1'b1, make_i(OP_ADDI, rand_reg(0), '0, imm_t'(raw)));
			end else if (sel == 1) begin
				do op = opcode_t'(rand_bits(6));
				while (op inside {OP_RTYPE, OP_ADDI, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_LUI});
				issue_slot(1'b1, {op, raw[25:0]});
			end else begin
				do fn = funct_t'(rand_bits(6));
				while (fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU});
				issue_slot(1'b1, make_r(fn, raw[4:0], raw[9:5], rand_reg(1)));
			end
			issue_slot(1'b1, make_r(FN_ADD, '0, rand_reg(0), rand_reg(1))); // Reads r0.
		end
		end_test();
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		checks      = 0;
		errors      = 0;
		tests_run   = 0;
		for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
		run_tests();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
isa_pkg.sv
pipe_pkg.sv
stage_if.sv
reg_file.sv
alu.sv
decode_stage.sv
execute_stage.sv
mips_int_pipe.sv
tb_mips_int_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_int_pipe
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a reported failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
